// ==== include/rf_params.svh ====
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// register file geometry, RAM width and register count.

`define RF_WIDTH 8

`define RF_CSR_REGS 4

`define RF_REG_COUNT (32 + `RF_CSR_REGS)

`define RF_DEPTH (32 * `RF_REG_COUNT / `RF_WIDTH)

`define RF_L2W 3

`endif

// ==== logic/rf_pkg.sv ====
`default_nettype none

`include "rf_params.svh"

package rf_pkg;

   typedef logic [$clog2(`RF_REG_COUNT)-1:0] reg_idx_t;

   // register index followed by the word select bits of the count.
   typedef logic [$clog2(`RF_DEPTH)-1:0] ram_addr_t;

   typedef logic [`RF_WIDTH-1:0] ram_word_t;

   typedef logic [4:0] bit_cnt_t;

   typedef enum logic [1:0] {
      IDLE,
      READ_WAIT,
      READ,
      WRITE
   } rf_state_t;

endpackage

`default_nettype wire

// ==== logic/rf_slot_if.sv ====
`default_nettype none

interface rf_slot_if;
   import rf_pkg::*;

   bit_cnt_t cnt;  // bit position of the read streams.
   bit_cnt_t wcnt; // write streams run three slots behind.
   logic     rtrig0;
   logic     rtrig1;
   logic     wtrig0;
   logic     wtrig1;

   modport counter (
      output cnt,
      output wcnt,
      output rtrig0,
      output rtrig1,
      output wtrig0,
      output wtrig1
   );

   modport reader (
      input cnt,
      input rtrig0,
      input rtrig1
   );

   modport writer (
      input wcnt,
      input wtrig0,
      input wtrig1
   );

endinterface

`default_nettype wire

// ==== logic/rf_sequencer.sv ====
`default_nettype none

module rf_sequencer (
   input  wire  i_clk,
   input  wire  i_rst,
   input  wire  i_rreq,
   input  wire  i_wreq,
   output logic o_ready,
   output logic o_load_read,
   output logic o_load_write,
   input  wire  i_cnt_wrap
);
   import rf_pkg::*;

   rf_state_t state;
   logic      wait_r;
   logic      rgnt;

   assign o_ready     = rgnt | i_wreq;
   assign o_load_read = (state == IDLE) & i_rreq; // read slots start on the request edge.

   always_ff @(posedge i_clk) begin
      rgnt         <= 1'b0;
      o_load_write <= 1'b0;
      case (state)
         IDLE: begin
            wait_r <= 1'b0;
            if (i_rreq) begin
               state <= READ_WAIT;
            end else if (i_wreq) begin
               state        <= WRITE;
               o_load_write <= 1'b1; // write slots start one edge later.
            end
         end
         READ_WAIT: begin
            wait_r <= 1'b1;
            if (wait_r) begin
               state <= READ;
               rgnt  <= 1'b1; // first byte pair is out of the RAM now.
            end
         end
         READ: begin
            if (i_cnt_wrap) begin
               state <= IDLE;
            end
         end
         WRITE: begin
            if (i_cnt_wrap && !o_load_write) begin
               state <= IDLE;
            end
         end
         default: state <= IDLE;
      endcase
      if (i_rst) begin
         state        <= IDLE;
         rgnt         <= 1'b0;
         o_load_write <= 1'b0;
      end
   end

   a_req_only_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_rreq || i_wreq) |-> (state == IDLE));

   a_single_req: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_rreq && i_wreq));

endmodule

`default_nettype wire

// ==== logic/rf_slot_counter.sv ====
`default_nettype none

`include "rf_params.svh"

module rf_slot_counter (
   input  wire        i_clk,
   input  wire        i_load_read,
   input  wire        i_load_write,
   output logic       o_cnt_wrap,
   rf_slot_if.counter slot
);
   import rf_pkg::*;

   localparam int unsigned RTRIG_SLOT = 1;
   localparam int unsigned WTRIG_SLOT = `RF_WIDTH - 2;

   bit_cnt_t cnt_r;

   // free running, so the slots of a finished transfer drain on their own.
   always_ff @(posedge i_clk) begin
      cnt_r <= cnt_r + bit_cnt_t'(1);
      if (i_load_read) begin
         cnt_r <= bit_cnt_t'(0);
      end
      if (i_load_write) begin
         cnt_r <= bit_cnt_t'(2);
      end
   end

   assign slot.cnt  = cnt_r;
   assign slot.wcnt = cnt_r - bit_cnt_t'(3);

   assign slot.rtrig0 = (cnt_r[`RF_L2W-1:0] == RTRIG_SLOT[`RF_L2W-1:0]);
   assign slot.wtrig0 = (slot.wcnt[`RF_L2W-1:0] == WTRIG_SLOT[`RF_L2W-1:0]);

   always_ff @(posedge i_clk) begin
      slot.rtrig1 <= slot.rtrig0;
      slot.wtrig1 <= slot.wtrig0;
   end

   assign o_cnt_wrap = (cnt_r == bit_cnt_t'(0)); // one bit of the transfer is left.

   // the first read slot follows the loaded count by one cycle.
   a_read_slot: assert property (@(posedge i_clk)
      $past(i_load_read, 2) |-> slot.rtrig0);

endmodule

`default_nettype wire

// ==== logic/rf_read_serializer.sv ====
`default_nettype none

`include "rf_params.svh"

module rf_read_serializer (
   input  wire rf_pkg::reg_idx_t  i_rreg0,
   input  wire rf_pkg::reg_idx_t  i_rreg1,
   input  wire                    i_clk,
   output rf_pkg::ram_addr_t      o_raddr,
   input  wire rf_pkg::ram_word_t i_rdata,
   output logic                   o_rdata0,
   output logic                   o_rdata1,
   rf_slot_if.reader              slot
);
   import rf_pkg::*;

   reg_idx_t             rreg;
   ram_word_t            rdata0_r;
   logic [`RF_WIDTH-2:0] rdata1_r;

   // the second register is fetched in the slot right after the first.
   assign rreg    = slot.rtrig0 ? i_rreg1 : i_rreg0;
   assign o_raddr = {rreg, slot.cnt[$bits(bit_cnt_t)-1:`RF_L2W]};

   assign o_rdata0 = rdata0_r[0];
   assign o_rdata1 = slot.rtrig1 ? i_rdata[0] : rdata1_r[0]; // bit 0 bypasses the register.

   always_ff @(posedge i_clk) begin
      rdata0_r <= {1'b0, rdata0_r[`RF_WIDTH-1:1]};
      if (slot.rtrig0) begin
         rdata0_r <= i_rdata;
      end
   end

   always_ff @(posedge i_clk) begin
      rdata1_r <= {1'b0, rdata1_r[`RF_WIDTH-2:1]};
      if (slot.rtrig1) begin
         rdata1_r <= i_rdata[`RF_WIDTH-1:1];
      end
   end

endmodule

`default_nettype wire

// ==== logic/rf_write_deserializer.sv ====
`default_nettype none

`include "rf_params.svh"

module rf_write_deserializer (
   input  wire                   i_clk,
   input  wire rf_pkg::reg_idx_t i_wreg0,
   input  wire rf_pkg::reg_idx_t i_wreg1,
   input  wire                   i_wen0,
   input  wire                   i_wen1,
   input  wire                   i_wdata0,
   input  wire                   i_wdata1,
   output rf_pkg::ram_addr_t     o_waddr,
   output rf_pkg::ram_word_t     o_wdata,
   output logic                  o_wen,
   rf_slot_if.writer             slot
);
   import rf_pkg::*;

   logic [`RF_WIDTH-2:0] wdata0_r;
   ram_word_t            wdata1_r;
   logic                 wen0_r;
   logic                 wen1_r;
   reg_idx_t             wreg;

   // stream 0 is written with its last bit still on the input.
   always_ff @(posedge i_clk) begin
      wdata0_r <= {i_wdata0, wdata0_r[`RF_WIDTH-2:1]};
      wdata1_r <= {i_wdata1, wdata1_r[`RF_WIDTH-1:1]};
   end

   // the slots keep running between transfers, so the enables stay low then.
   always_ff @(posedge i_clk) begin
      wen0_r <= i_wen0;
      wen1_r <= i_wen1;
   end

   assign wreg    = slot.wtrig1 ? i_wreg1 : i_wreg0;
   assign o_waddr = {wreg, slot.wcnt[$bits(bit_cnt_t)-1:`RF_L2W]};

   assign o_wdata = slot.wtrig1 ? wdata1_r : {i_wdata0, wdata0_r};

   assign o_wen = (slot.wtrig0 & wen0_r) | (slot.wtrig1 & wen1_r);

endmodule

`default_nettype wire

// ==== logic/rf_ram.sv ====
`default_nettype none

`include "rf_params.svh"

module rf_ram (
   input  wire                    i_clk,
   input  wire rf_pkg::ram_addr_t i_waddr,
   input  wire rf_pkg::ram_word_t i_wdata,
   input  wire                    i_wen,
   input  wire rf_pkg::ram_addr_t i_raddr,
   output rf_pkg::ram_word_t      o_rdata
);
   import rf_pkg::*;

   ram_word_t mem [`RF_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr]; // old data on a same-address collision.
   end

endmodule

`default_nettype wire

// ==== logic/serial_rf_top.sv ====
`default_nettype none

`include "rf_params.svh"

module serial_rf_top (
   input  wire                               i_clk,
   input  wire                               i_rst,
   input  wire                               i_rreq,
   input  wire                               i_wreq,
   output logic                              o_ready,
   input  wire [$clog2(`RF_REG_COUNT)-1:0]   i_wreg0,
   input  wire [$clog2(`RF_REG_COUNT)-1:0]   i_wreg1,
   input  wire                               i_wen0,
   input  wire                               i_wen1,
   input  wire                               i_wdata0,
   input  wire                               i_wdata1,
   input  wire [$clog2(`RF_REG_COUNT)-1:0]   i_rreg0,
   input  wire [$clog2(`RF_REG_COUNT)-1:0]   i_rreg1,
   output logic                              o_rdata0,
   output logic                              o_rdata1
);
   import rf_pkg::*;

   logic      load_read;
   logic      load_write;
   logic      cnt_wrap;
   ram_addr_t waddr;
   ram_word_t wdata;
   logic      wen;
   ram_addr_t raddr;
   ram_word_t rdata;

   rf_slot_if slot ();

   rf_sequencer u_sequencer (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_rreq       (i_rreq),
      .i_wreq       (i_wreq),
      .o_ready      (o_ready),
      .o_load_read  (load_read),
      .o_load_write (load_write),
      .i_cnt_wrap   (cnt_wrap)
   );

   rf_slot_counter u_counter (
      .i_clk        (i_clk),
      .i_load_read  (load_read),
      .i_load_write (load_write),
      .o_cnt_wrap   (cnt_wrap),
      .slot         (slot.counter)
   );

   rf_read_serializer u_reader (
      .i_clk    (i_clk),
      .i_rreg0  (i_rreg0),
      .i_rreg1  (i_rreg1),
      .o_raddr  (raddr),
      .i_rdata  (rdata),
      .o_rdata0 (o_rdata0),
      .o_rdata1 (o_rdata1),
      .slot     (slot.reader)
   );

   rf_write_deserializer u_writer (
      .i_clk    (i_clk),
      .i_wreg0  (i_wreg0),
      .i_wreg1  (i_wreg1),
      .i_wen0   (i_wen0),
      .i_wen1   (i_wen1),
      .i_wdata0 (i_wdata0),
      .i_wdata1 (i_wdata1),
      .o_waddr  (waddr),
      .o_wdata  (wdata),
      .o_wen    (wen),
      .slot     (slot.writer)
   );

   rf_ram u_ram (
      .i_clk   (i_clk),
      .i_waddr (waddr),
      .i_wdata (wdata),
      .i_wen   (wen),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

endmodule

`default_nettype wire

// ==== verification/serial_rf_tb.sv ====
`default_nettype none

`include "rf_params.svh"

module serial_rf_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import rf_pkg::*;

   typedef logic [31:0] word_t;

   typedef struct packed {
      logic     is_write;
      reg_idx_t reg0;
      reg_idx_t reg1;
      logic     en0;
      logic     en1;
      word_t    val0;
      word_t    val1;
   } row_t;

   localparam int NUM_ROWS    = 20;
   localparam int CLK_NS      = 40;
   localparam int READY_LIMIT = 8;

   logic     clk;
   logic     rst;
   logic     rreq;
   logic     wreq;
   logic     ready;
   reg_idx_t wreg0;
   reg_idx_t wreg1;
   logic     wen0;
   logic     wen1;
   logic     wdata0;
   logic     wdata1;
   reg_idx_t rreg0;
   reg_idx_t rreg1;
   logic     rdata0;
   logic     rdata1;

   row_t        rows [NUM_ROWS];
   int          row_count;
   word_t       shadow [`RF_REG_COUNT]; // expected register contents.
   logic [15:0] lfsr;
   int          failures;

   serial_rf_top UUT (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_rreq   (rreq),
      .i_wreq   (wreq),
      .o_ready  (ready),
      .i_wreg0  (wreg0),
      .i_wreg1  (wreg1),
      .i_wen0   (wen0),
      .i_wen1   (wen1),
      .i_wdata0 (wdata0),
      .i_wdata1 (wdata1),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1)
   );

   always #(CLK_NS / 2) clk = ~clk;

   task automatic stop_on_failure();
      failures++;
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first failing check");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_on_failure();
      end
   endtask

   // taps 16, 14, 13 and 11.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic next_random_word(output word_t w);
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsr_step(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   task automatic add_write(input reg_idx_t r0, input reg_idx_t r1, input logic e0,
                            input logic e1);
      row_t row;
      row.is_write = 1'b1;
      row.reg0     = r0;
      row.reg1     = r1;
      row.en0      = e0;
      row.en1      = e1;
      next_random_word(row.val0);
      next_random_word(row.val1);
      if (e0) shadow[r0] = row.val0;
      if (e1) shadow[r1] = row.val1; // stream 1 lands one slot after stream 0.
      rows[row_count] = row;
      row_count++;
   endtask

   task automatic add_read(input reg_idx_t r0, input reg_idx_t r1);
      row_t row;
      row.is_write = 1'b0;
      row.reg0     = r0;
      row.reg1     = r1;
      row.en0      = 1'b0;
      row.en1      = 1'b0;
      row.val0     = shadow[r0];
      row.val1     = shadow[r1];
      rows[row_count] = row;
      row_count++;
   endtask

   task automatic build_table();
      add_write(5, 9, 1'b1, 1'b1);
      add_read(5, 9);
      add_write(5, 9, 1'b1, 1'b0);
      add_read(5, 9);
      add_write(5, 9, 1'b0, 1'b1);
      add_read(5, 9);
      add_write(32, 33, 1'b1, 1'b1);
      add_write(34, 35, 1'b1, 1'b1);
      add_write(0, 1, 1'b1, 1'b1);
      add_write(2, 3, 1'b1, 1'b1);
      add_read(33, 32);
      add_read(35, 34);
      add_read(1, 0);
      add_read(3, 2);
      add_write(10, 11, 1'b1, 1'b1);
      add_read(10, 11);
      add_write(20, 21, 1'b1, 1'b1);
      add_read(21, 20);
      add_write(7, 30, 1'b1, 1'b1);
      add_read(7, 30);
   endtask

   // entered just after a rising edge, returns on the edge that samples bit 31.
   task automatic do_write(input row_t row);
      wreq <= 1'b1;
      @(negedge clk);
      check_bit("o_ready with i_wreq", ready, 1'b1);
      @(posedge clk);
      wreq <= 1'b0;
      @(negedge clk);
      check_bit("o_ready after i_wreq", ready, 1'b0);
      @(posedge clk);
      wreg0 <= row.reg0; // indices follow with bit 0 so the last byte of a prior write is safe.
      wreg1 <= row.reg1;
      wen0  <= row.en0;
      wen1  <= row.en1;
      for (int k = 0; k < 32; k++) begin
         wdata0 <= row.val0[k];
         wdata1 <= row.val1[k];
         @(posedge clk);
      end
      wen0 <= 1'b0;
      wen1 <= 1'b0;
   endtask

   task automatic do_read(input row_t row);
      int    lat;
      word_t got0;
      word_t got1;
      rreq  <= 1'b1;
      rreg0 <= row.reg0;
      rreg1 <= row.reg1;
      @(posedge clk);
      rreq <= 1'b0;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
         if (lat > READY_LIMIT) begin
            $display("o_ready never rose after a read request");
            stop_on_failure();
         end
      end while (ready !== 1'b1);
      if (lat != 3) begin
         $display("o_ready rose %0d cycles after the read request edge instead of 3", lat);
         stop_on_failure();
      end
      for (int k = 0; k < 32; k++) begin
         got0[k] = rdata0;
         got1[k] = rdata1;
         if (k == 1) check_bit("o_ready during read", ready, 1'b0);
         if (k < 31) @(negedge clk);
      end
      check_word($sformatf("o_rdata0 of x%0d", row.reg0), got0, row.val0);
      check_word($sformatf("o_rdata1 of x%0d", row.reg1), got1, row.val1);
      @(posedge clk);
   endtask

   initial begin
      #(NUM_ROWS * 40 * CLK_NS + 200 * CLK_NS);
      $display("watchdog expired before the test table was finished");
      stop_on_failure();
   end

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      rreq      = 1'b0;
      wreq      = 1'b0;
      wreg0     = '0;
      wreg1     = '0;
      wen0      = 1'b0;
      wen1      = 1'b0;
      wdata0    = 1'b0;
      wdata1    = 1'b0;
      rreg0     = '0;
      rreg1     = '0;
      failures  = 0;
      row_count = 0;
      lfsr      = 16'd30;
      build_table();
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      repeat (4) begin
         @(negedge clk);
         check_bit("o_ready after reset", ready, 1'b0);
      end
      @(posedge clk);
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (rows[i].is_write) begin
            do_write(rows[i]);
         end else begin
            do_read(rows[i]);
         end
      end
      if (failures == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         stop_on_failure();
      end
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/rf_pkg.sv
logic/rf_slot_if.sv
logic/rf_sequencer.sv
logic/rf_slot_counter.sv
logic/rf_read_serializer.sv
logic/rf_write_deserializer.sv
logic/rf_ram.sv
logic/serial_rf_top.sv
verification/serial_rf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module serial_rf_tb -o serial_rf_sim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/serial_rf_sim > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
